//--- hw/batchController.sv
`timescale 1ns/100ps

module batchController (
    input  logic clk,
    input  logic arstN,
    input  logic empty,
    input  logic headBatchDone,
    input  logic grabResults,
    output logic pop,
    output logic clearTotals,
    output logic resultsAvailable
);

    permutePkg::ctrlState state;
    permutePkg::ctrlState stateNext;

    // One entry per cycle while running
    assign pop = (state == permutePkg::ctrlRun) && !empty;

    // Clear lands on the same edge that leaves the hold
    assign clearTotals = (state == permutePkg::ctrlHold) && grabResults;

    assign resultsAvailable = (state == permutePkg::ctrlHold);

    always_comb begin
        stateNext = state;
        unique case (state)
            permutePkg::ctrlIdle: begin
                stateNext = permutePkg::ctrlRun;
            end
            permutePkg::ctrlRun: begin
                if (pop && headBatchDone) begin
                    stateNext = permutePkg::ctrlHold; // Totals include this entry
                end
            end
            permutePkg::ctrlHold: begin
                if (grabResults) begin
                    stateNext = permutePkg::ctrlRun;
                end
            end
            default: begin
                stateNext = permutePkg::ctrlIdle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= permutePkg::ctrlIdle;
        end else begin
            state <= stateNext;
        end
    end

endmodule

//--- hw/botFifo.sv
`timescale 1ns/100ps

module botFifo (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 writeEnable,
    input  permutePkg::fifoEntry entry,
    input  logic                 pop,
    output permutePkg::fifoEntry head,
    output logic                 empty,
    output logic                 slowDownInput
);

    permutePkg::fifoEntry mem [permutePkg::fifoDepth];

    permutePkg::fifoPtr   wrPtr;
    permutePkg::fifoPtr   rdPtr;
    permutePkg::fifoLevel count; // Occupancy
    logic                 full;
    logic                 doWrite;
    logic                 doPop;

    assign full    = (count == permutePkg::fifoLevel'(permutePkg::fifoDepth));
    assign empty   = (count == '0);
    assign doWrite = writeEnable && !full; // Dropped when full
    assign doPop   = pop && !empty;

    // First word fall through
    assign head = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= entry;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1; // Wraps at the depth
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doWrite, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Threshold flag lags the level by one cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            slowDownInput <= 1'b0;
        end else begin
            slowDownInput <= (count > permutePkg::fifoLevel'(permutePkg::slowThreshold));
        end
    end

endmodule

//--- hw/coeffAccumulator.sv
`timescale 1ns/100ps

module coeffAccumulator (
    input  logic                 clk,
    input  logic                 arstN,
    input  permutePkg::fifoEntry head,
    input  logic                 accumulate,
    input  logic                 clearTotals,
    output permutePkg::sumT      pcoeffSum,
    output permutePkg::countT    pcoeffCount
);

    permutePkg::permMask mask;
    permutePkg::sumT     entrySum;
    permutePkg::countT   entryCount;

    assign mask = head[1 +: permutePkg::permCount];

    // Contribution of the head entry
    always_comb begin
        entrySum = '0;
        entryCount = '0;
        for (int p = 0; p < permutePkg::permCount; p++) begin
            if (mask[p]) begin
                entrySum = entrySum + permutePkg::sumT'(
                    head[1 + permutePkg::permCount + permutePkg::termWidth * p +:
                         permutePkg::termWidth]);
                entryCount = entryCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcoeffSum   <= '0;
            pcoeffCount <= '0;
        end else if (clearTotals) begin
            pcoeffSum   <= '0;
            pcoeffCount <= '0;
        end else if (accumulate) begin
            pcoeffSum   <= pcoeffSum + entrySum;
            pcoeffCount <= pcoeffCount + entryCount;
        end
    end

endmodule

//--- hw/permuteAggregator.sv
`timescale 1ns/100ps

module permuteAggregator (
    input  logic                  clk,
    input  logic                  arstN,
    input  permutePkg::truthTable top,
    input  permutePkg::truthTable bot,
    input  logic                  isBotValid,
    input  logic                  batchDone,
    output logic                  slowDownInput,
    input  logic                  grabResults,
    output logic                  resultsAvailable,
    output permutePkg::sumT       pcoeffSum,
    output permutePkg::countT     pcoeffCount
);

    logic                 writeEnable;
    permutePkg::fifoEntry entry;
    permutePkg::fifoEntry head;
    logic                 empty;
    logic                 pop;
    logic                 clearTotals;

    permuteChecker checker_i (
        .clk         (clk),
        .arstN       (arstN),
        .top         (top),
        .bot         (bot),
        .isBotValid  (isBotValid),
        .batchDone   (batchDone),
        .writeEnable (writeEnable),
        .entry       (entry)
    );

    botFifo fifo_i (
        .clk           (clk),
        .arstN         (arstN),
        .writeEnable   (writeEnable),
        .entry         (entry),
        .pop           (pop),
        .head          (head),
        .empty         (empty),
        .slowDownInput (slowDownInput)
    );

    batchController ctrl_i (
        .clk              (clk),
        .arstN            (arstN),
        .empty            (empty),
        .headBatchDone    (head[0]),   // Batch end flag of the head entry
        .grabResults      (grabResults),
        .pop              (pop),
        .clearTotals      (clearTotals),
        .resultsAvailable (resultsAvailable)
    );

    coeffAccumulator accum_i (
        .clk         (clk),
        .arstN       (arstN),
        .head        (head),
        .accumulate  (pop),            // Accumulate in the pop cycle
        .clearTotals (clearTotals),
        .pcoeffSum   (pcoeffSum),
        .pcoeffCount (pcoeffCount)
    );

endmodule

//--- hw/permuteChecker.sv
`timescale 1ns/100ps

module permuteChecker (
    input  logic                  clk,
    input  logic                  arstN,
    input  permutePkg::truthTable top,
    input  permutePkg::truthTable bot,
    input  logic                  isBotValid,
    input  logic                  batchDone,
    output logic                  writeEnable,
    output permutePkg::fifoEntry  entry
);

    // Exchange variables 3 and k by remapping every table index
    function automatic permutePkg::truthTable swapVars(permutePkg::truthTable t, int k);
        permutePkg::truthTable s;
        logic [6:0] idx;
        logic [6:0] src;
        for (int i = 0; i < 128; i++) begin
            idx = 7'(i);
            src = idx;
            src[3] = idx[k];
            src[k] = idx[3];
            s[i] = t[src];
        end
        return s;
    endfunction

    // Ones in the half where variable 6 is 0
    function automatic permutePkg::termT lowerOnes(permutePkg::truthTable t);
        permutePkg::termT n;
        n = '0;
        for (int i = 0; i < 64; i++) begin
            n = n + permutePkg::termT'(t[i]);
        end
        return n;
    endfunction

    permutePkg::truthTable permTable [permutePkg::permCount];
    permutePkg::permMask   mask;
    permutePkg::fifoEntry  entryNext;

    always_comb begin
        entryNext = '0;
        for (int p = 0; p < permutePkg::permCount; p++) begin
            // p = 0 swaps variable 3 with itself and gives the identity
            permTable[p] = swapVars(bot, p + 3);
            mask[p] = isBotValid && ((permTable[p] & ~top) == '0);
            entryNext[1 + permutePkg::permCount + permutePkg::termWidth * p +:
                      permutePkg::termWidth] = lowerOnes(permTable[p]);
        end
        entryNext[1 +: permutePkg::permCount] = mask;
        entryNext[0] = batchDone;
    end

    // Only entries that carry work go to the FIFO
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            writeEnable <= 1'b0;
        end else begin
            writeEnable <= (|mask) || batchDone;
        end
    end

    always_ff @(posedge clk) begin
        entry <= entryNext;
    end

endmodule

//--- hw/permutePkg.sv
package permutePkg;

    // Truth table of one 7-input function
    typedef logic [127:0] truthTable;

    localparam int permCount = 4; // Identity plus swaps 3-4, 3-5, 3-6
    localparam int termWidth = 7; // Holds 0 to 64
    localparam int entryWidth = permCount * termWidth + permCount + 1;

    typedef logic [permCount-1:0] permMask;
    typedef logic [termWidth-1:0] termT;

    // Four terms, then the mask, then batchDone in bit 0
    typedef logic [entryWidth-1:0] fifoEntry;

    localparam int fifoDepthLog2 = 4;
    localparam int fifoDepth = 2 ** fifoDepthLog2;
    localparam int slowThreshold = 8; // Entries held before asking the source to stop

    typedef logic [fifoDepthLog2-1:0] fifoPtr;
    typedef logic [fifoDepthLog2:0] fifoLevel; // One extra bit to reach a full count

    localparam int countWidth = 12;
    localparam int sumWidth = 18;

    typedef logic [countWidth-1:0] countT;
    typedef logic [sumWidth-1:0] sumT;

    typedef enum logic [1:0] {
        ctrlIdle,
        ctrlRun,
        ctrlHold
    } ctrlState;

endpackage

//--- sim.f
hw/permutePkg.sv
hw/permuteChecker.sv
hw/botFifo.sv
hw/batchController.sv
hw/coeffAccumulator.sv
hw/permuteAggregator.sv
verif/permuteAggregator_assertions.sv
verif/permuteAggregatorTb.sv

//--- verif/permuteAggregatorTb.sv
`timescale 1ns/100ps

module permuteAggregatorTb;

    typedef struct packed {
        permutePkg::truthTable top;
        permutePkg::truthTable bot;
        logic                  valid;
        logic                  done;
        logic [31:0]           grabDelay; // Host wait before grabbing, used on batch end rows
    } stimRow;

    localparam int waitLimit = 5000; // Cycles allowed for any single wait

    logic clk = 1'b0;
    logic arstN;
    permutePkg::truthTable top;
    permutePkg::truthTable bot;
    logic isBotValid;
    logic batchDone;
    logic slowDownInput;
    logic grabResults;
    logic resultsAvailable;
    permutePkg::sumT pcoeffSum;
    permutePkg::countT pcoeffCount;

    stimRow rows[$];
    int expSum[$];
    int expCount[$];
    int grabDelays[$];
    int modelSum;
    int modelCount;
    logic [31:0] rngState;
    int errorCount;
    int checkCount;
    logic aborted;
    logic sawSlowDown;

    always #10 clk = ~clk;

    permuteAggregator dut_i (
        .clk              (clk),
        .arstN            (arstN),
        .top              (top),
        .bot              (bot),
        .isBotValid       (isBotValid),
        .batchDone        (batchDone),
        .slowDownInput    (slowDownInput),
        .grabResults      (grabResults),
        .resultsAvailable (resultsAvailable),
        .pcoeffSum        (pcoeffSum),
        .pcoeffCount      (pcoeffCount)
    );

    bind permuteAggregator permuteAggregatorAssertions assertions_i (
        .clk              (clk),
        .arstN            (arstN),
        .writeEnable      (writeEnable),
        .pop              (pop),
        .resultsAvailable (resultsAvailable),
        .rdPtr            (fifo_i.rdPtr),
        .pcoeffSum        (pcoeffSum),
        .pcoeffCount      (pcoeffCount)
    );

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic permutePkg::truthTable randomTable();
        return {xorshift32(), xorshift32(), xorshift32(), xorshift32()};
    endfunction

    // Input combination i reads from the one with bits 3 and k exchanged
    function automatic permutePkg::truthTable swapModel(permutePkg::truthTable t, int k);
        permutePkg::truthTable s;
        int j;
        for (int i = 0; i < 128; i++) begin
            j = i;
            if (((i >> 3) & 1) != ((i >> k) & 1)) begin
                j = i ^ (8 | (1 << k));
            end
            s[i] = t[j];
        end
        return s;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Appends a row and folds it into the per batch reference totals
    task automatic addRow(input permutePkg::truthTable t, input permutePkg::truthTable b,
                          input logic v, input logic d, input int delay);
        permutePkg::truthTable p;
        rows.push_back('{t, b, v, d, delay});
        if (v) begin
            for (int k = 3; k < 7; k++) begin
                p = swapModel(b, k);
                if ((p & ~t) == '0) begin
                    modelSum += $countones(p[63:0]);
                    modelCount++;
                end
            end
        end
        if (d) begin
            expSum.push_back(modelSum);
            expCount.push_back(modelCount);
            grabDelays.push_back(delay);
            modelSum = 0;
            modelCount = 0;
        end
    endtask

    task automatic driveRows();
        int n;
        foreach (rows[i]) begin
            n = 0;
            while (slowDownInput && n < waitLimit && !aborted) begin
                sawSlowDown = 1'b1;
                isBotValid = 1'b0; // Source pauses
                batchDone = 1'b0;
                @(negedge clk);
                n++;
            end
            if (slowDownInput || aborted) begin
                if (!aborted) begin
                    $display("Timeout: slowDownInput did not fall before row %0d", i);
                    errorCount++;
                end
                aborted = 1'b1;
                break;
            end
            top = rows[i].top;
            bot = rows[i].bot;
            isBotValid = rows[i].valid;
            batchDone = rows[i].done;
            @(negedge clk);
        end
        isBotValid = 1'b0;
        batchDone = 1'b0;
    endtask

    task automatic collectResults();
        int n;
        for (int b = 0; b < expSum.size() && !aborted; b++) begin
            n = 0;
            while (!resultsAvailable && n < waitLimit && !aborted) begin
                @(negedge clk);
                n++;
            end
            if (!resultsAvailable) begin
                if (!aborted) begin
                    $display("Timeout: resultsAvailable never rose for batch %0d", b);
                    errorCount++;
                end
                aborted = 1'b1;
            end else begin
                checkValue($sformatf("batch %0d sum", b), pcoeffSum, expSum[b]);
                checkValue($sformatf("batch %0d count", b), pcoeffCount, expCount[b]);
                repeat (grabDelays[b]) @(negedge clk);
                grabResults = 1'b1;
                @(negedge clk);
                grabResults = 1'b0;
                checkValue($sformatf("batch %0d resultsAvailable after grab", b),
                           resultsAvailable, 0);
                checkValue($sformatf("batch %0d sum after grab", b), pcoeffSum, 0);
                checkValue($sformatf("batch %0d count after grab", b), pcoeffCount, 0);
            end
        end
    endtask

    initial begin
        permutePkg::truthTable t;
        int nRows;
        int kind;
        rngState = 32'h662c_1940;
        arstN = 1'b0;
        top = '0;
        bot = '0;
        isBotValid = 1'b0;
        batchDone = 1'b0;
        grabResults = 1'b0;
        errorCount = 0;
        checkCount = 0;
        modelSum = 0;
        modelCount = 0;
        aborted = 1'b0;
        sawSlowDown = 1'b0;

        // Single ones on index 8 so each bot fits top under exactly one permutation
        addRow(128'h100, 128'h100, 1'b1, 1'b0, 0);
        addRow(128'h100, 128'h1_0000, 1'b1, 1'b0, 0);
        addRow(128'h100, 128'h1_0000_0000, 1'b1, 1'b0, 0);
        addRow(128'h100, 128'h1_0000_0000_0000_0000, 1'b1, 1'b1, 2);
        addRow('1, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210, 1'b1, 1'b0, 0);
        addRow('1, 128'hf0f0_0000_0f0f_ffff_0000_1234_8000_0001, 1'b1, 1'b1, 1);

        // Nothing fits an empty top, then a lone batch end
        for (int r = 0; r < 3; r++) begin
            addRow('0, randomTable(), 1'b1, 1'b0, 0);
        end
        addRow('0, '0, 1'b0, 1'b1, 0);

        // Slow host with batches queued behind the first
        for (int b = 0; b < 4; b++) begin
            for (int r = 0; r < 5; r++) begin
                addRow('1, randomTable(), 1'b1, r == 4, (b == 0) ? 60 : 30);
            end
        end

        for (int b = 0; b < 40; b++) begin
            t = randomTable() | randomTable();
            nRows = 1 + int'(xorshift32() % 5);
            for (int r = 0; r < nRows; r++) begin
                kind = int'(xorshift32() % 8);
                if (kind < 4) begin
                    addRow(t, swapModel(t & randomTable(), 3 + kind), 1'b1, r == nRows - 1,
                           int'(xorshift32() % 8));
                end else if (kind == 4) begin
                    addRow(t, randomTable(), 1'b0, r == nRows - 1, int'(xorshift32() % 8));
                end else if (kind == 5) begin
                    addRow(t, randomTable(), 1'b1, r == nRows - 1, int'(xorshift32() % 8));
                end else begin
                    addRow(t, t & randomTable(), 1'b1, r == nRows - 1, int'(xorshift32() % 8));
                end
            end
        end

        repeat (8) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        checkValue("resultsAvailable after reset", resultsAvailable, 0);
        checkValue("slowDownInput after reset", slowDownInput, 0);

        fork
            driveRows();
            collectResults();
        join

        checkValue("slowDownInput seen high", sawSlowDown, 1);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verif/permuteAggregator_assertions.sv
`timescale 1ns/100ps

module permuteAggregatorAssertions (
    input logic               clk,
    input logic               arstN,
    input logic               writeEnable,
    input logic               pop,
    input logic               resultsAvailable,
    input permutePkg::fifoPtr rdPtr, // Read pointer inside the FIFO
    input permutePkg::sumT    pcoeffSum,
    input permutePkg::countT  pcoeffCount
);

    // Shadow occupancy built from the FIFO's write and pop strobes
    permutePkg::fifoLevel fill;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fill <= '0;
        end else begin
            case ({writeEnable, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    noWriteWhenFull: assert property (@(posedge clk) disable iff (!arstN)
        writeEnable |-> (fill != permutePkg::fifoLevel'(permutePkg::fifoDepth)))
        else $error("FIFO written while full");

    totalsStableInHold: assert property (@(posedge clk) disable iff (!arstN)
        (resultsAvailable && $past(resultsAvailable)) |->
            ($stable(pcoeffSum) && $stable(pcoeffCount)))
        else $error("Totals changed while results were on offer");

    noPopInHold: assert property (@(posedge clk) disable iff (!arstN)
        resultsAvailable |=> $stable(rdPtr))
        else $error("Entry popped while results were on offer");

endmodule
